// ==== build.f ====
+incdir+rtl
rtl/aes_wrap_pkg.sv
rtl/aes_wrap_wb_regs.sv
rtl/aes_wrap_kv_capture.sv
rtl/aes_wrap_edn_arb.sv
rtl/aes_wrap_top.sv
sim/aes_wrap_properties.sv
sim/aes_wrap_tb.sv

// ==== rtl/aes_wrap_edn_arb.sv ====
/*
 * Entropy request arbiter
 * Fixed priority between clearing and masking requesters, with the
 * outgoing request held until acknowledged
 */
`timescale 1ns/1ps
`default_nettype none

module aes_wrap_edn_arb (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clearing_req_i,
  input  logic                   masking_req_i,
  output logic                   clearing_ack_o,
  output logic                   masking_ack_o,
  output logic                   edn_req_o,
  input  logic                   edn_ack_i,
  input  aes_wrap_pkg::entropy_t edn_data_i,
  output aes_wrap_pkg::entropy_t entropy_o
);

  logic req_hold_q;

  // Clearing wins when both request
  assign clearing_ack_o = clearing_req_i & edn_ack_i;
  assign masking_ack_o  = ~clearing_req_i & masking_req_i & edn_ack_i;

  // A request that drops early stays up towards the source until acked
  assign edn_req_o = clearing_req_i | masking_req_i | req_hold_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_hold_q <= 1'b0;
    end else begin
      req_hold_q <= edn_req_o & ~edn_ack_i;
    end
  end

  // Both requesters share the entropy bus
  assign entropy_o = edn_data_i;

endmodule

`default_nettype wire

// ==== rtl/aes_wrap_kv_capture.sv ====
/*
 * Key-vault intercept
 * Routes cipher output blocks into the key-vault buffer when armed,
 * conceals software reads and handles buffer clearing
 */
`timescale 1ns/1ps
`default_nettype none

`include "aes_wrap_settings.svh"

module aes_wrap_kv_capture (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Control from the register block
  input  logic                      kv_en_i,
  input  logic                      block_output_i,
  input  aes_wrap_pkg::key_size_t   key_size_i,
  input  logic                      din_we_i,
  input  aes_wrap_pkg::word_idx_t   din_idx_i,
  input  logic                      sw_dout_last_rd_i,
  input  logic                      data_out_clear_i,
  // Core side
  input  logic                      core_out_valid_i,
  input  aes_wrap_pkg::data_block_t core_block_i,
  input  logic                      core_idle_i,
  output logic                      core_dout_ack_o,
  // Key vault side
  input  logic                      clear_secrets_i,
  input  logic                      kv_write_done_i,
  output aes_wrap_pkg::kv_data_t    kv_data_o,
  output logic                      kv_valid_o,
  // Status back to the register block
  output logic                      output_valid_o,
  output logic                      dout_visible_o
);

  localparam int unsigned BlockBytes = `AES_WRAP_BLOCK_W / 8;

  logic                      intercept_q;
  logic                      intercept_end;
  logic                      arm;
  logic                      step;
  logic                      clear_all;
  logic                      idle_q;
  aes_wrap_pkg::chunk_idx_t  chunk_cnt_q;
  aes_wrap_pkg::chunk_idx_t  last_chunk;
  aes_wrap_pkg::key_size_t   key_blocks;
  aes_wrap_pkg::data_block_t block_q;

  //////////////////////////////////////////////////////////////////////
  // Arming
  //////////////////////////////////////////////////////////////////////

  // Firmware arms before the operation by writing data-in word 0
  assign arm = din_we_i && (din_idx_i == '0) && (chunk_cnt_q == '0);

  assign key_blocks = key_size_i / aes_wrap_pkg::key_size_t'(BlockBytes);
  assign last_chunk = aes_wrap_pkg::chunk_idx_t'(key_blocks - aes_wrap_pkg::key_size_t'(1));

  // Operation ends when the core goes idle with the final chunk captured
  assign intercept_end = intercept_q && core_idle_i && !idle_q && (chunk_cnt_q == last_chunk);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intercept_q    <= 1'b0;
      dout_visible_o <= 1'b0;
    end else if (arm) begin
      intercept_q    <= kv_en_i;
      dout_visible_o <= ~kv_en_i & ~block_output_i;
    end else if (intercept_end) begin
      intercept_q    <= 1'b0;
      dout_visible_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idle_q <= 1'b0;
    end else begin
      idle_q <= core_idle_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output-valid latch and block consumption
  //////////////////////////////////////////////////////////////////////

  // Held until the block is consumed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      output_valid_o <= 1'b0;
    end else if (core_out_valid_i) begin
      output_valid_o <= 1'b1;
    end else if (core_dout_ack_o) begin
      output_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (core_out_valid_i) begin
      block_q <= core_block_i;
    end
  end

  // Hardware consumes the block itself when routing to the vault
  assign step            = intercept_q & output_valid_o;
  assign core_dout_ack_o = intercept_q ? output_valid_o : (sw_dout_last_rd_i & output_valid_o);

  //////////////////////////////////////////////////////////////////////
  // Chunk counter and capture buffer
  //////////////////////////////////////////////////////////////////////

  // Pegs at the last chunk for outputs longer than the key
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chunk_cnt_q <= '0;
    end else if (!intercept_q) begin
      chunk_cnt_q <= '0;
    end else if (step && (chunk_cnt_q != last_chunk)) begin
      chunk_cnt_q <= chunk_cnt_q + 1'b1;
    end
  end

  assign clear_all = clear_secrets_i | data_out_clear_i | kv_write_done_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      kv_data_o <= '0;
    end else if (clear_all) begin
      kv_data_o <= '0;
    end else if (step) begin
      kv_data_o[chunk_cnt_q*`AES_WRAP_BLOCK_W +: `AES_WRAP_BLOCK_W] <= block_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      kv_valid_o <= 1'b0;
    end else if (clear_all) begin
      kv_valid_o <= 1'b0;
    end else if (intercept_end) begin
      kv_valid_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/aes_wrap_pkg.sv ====
/*
 * AES wrapper package
 * Vector types for bus words, cipher blocks and the key-vault buffer
 */
`default_nettype none

`include "aes_wrap_settings.svh"

package aes_wrap_pkg;

  // Bus side
  typedef logic [`AES_WRAP_ADDR_W-1:0] wb_addr_t;
  typedef logic [`AES_WRAP_WORD_W-1:0] wb_data_t;
  typedef logic [$clog2(`AES_WRAP_BLOCK_W / `AES_WRAP_WORD_W)-1:0] word_idx_t;

  // Cipher output and key vault
  typedef logic [`AES_WRAP_BLOCK_W-1:0]            data_block_t;
  typedef logic [`AES_WRAP_KV_W-1:0]               kv_data_t;
  typedef logic [$clog2(`AES_WRAP_NUM_CHUNKS)-1:0] chunk_idx_t;
  typedef logic [`AES_WRAP_KSIZE_W-1:0]            key_size_t;

  // Entropy
  typedef logic [`AES_WRAP_ENTROPY_W-1:0] entropy_t;

endpackage

`default_nettype wire

// ==== rtl/aes_wrap_settings.svh ====
/*
 * AES wrapper settings
 * Widths, register word map and bit positions shared by the wrapper
 */
`ifndef AES_WRAP_SETTINGS_SVH
`define AES_WRAP_SETTINGS_SVH

// Widths
`define AES_WRAP_WORD_W      32
`define AES_WRAP_BLOCK_W     128
`define AES_WRAP_KV_W        512
`define AES_WRAP_NUM_CHUNKS  4
`define AES_WRAP_ADDR_W      4
`define AES_WRAP_ENTROPY_W   32
`define AES_WRAP_KSIZE_W     7

// Register word addresses
`define AES_WRAP_ADDR_CTRL       0
`define AES_WRAP_ADDR_TRIGGER    1
`define AES_WRAP_ADDR_STATUS     2
`define AES_WRAP_ADDR_DATA_IN0   4
`define AES_WRAP_ADDR_DATA_OUT0  8

// CTRL fields
`define AES_WRAP_CTRL_KV_EN       0
`define AES_WRAP_CTRL_BLOCK       1
`define AES_WRAP_CTRL_KSIZE_LSB   8

// STATUS fields
`define AES_WRAP_STATUS_OUTPUT_VALID  0
`define AES_WRAP_STATUS_OUTPUT_LOST   1
`define AES_WRAP_STATUS_KV_VALID      2

`endif

// ==== rtl/aes_wrap_top.sv ====
/*
 * AES host-side wrapper
 * Register block, key-vault intercept and entropy arbiter around
 * an external cipher core
 */
`timescale 1ns/1ps
`default_nettype none

module aes_wrap_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Wishbone
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  aes_wrap_pkg::wb_addr_t    wb_adr_i,
  input  aes_wrap_pkg::wb_data_t    wb_dat_i,
  output aes_wrap_pkg::wb_data_t    wb_dat_o,
  output logic                      wb_ack_o,
  // Cipher core
  output aes_wrap_pkg::wb_data_t    core_din_o,
  output aes_wrap_pkg::word_idx_t   core_din_idx_o,
  output logic                      core_din_we_o,
  input  aes_wrap_pkg::data_block_t core_block_i,
  input  logic                      core_out_valid_i,
  output logic                      core_dout_ack_o,
  input  logic                      core_idle_i,
  // Entropy
  input  logic                      clearing_req_i,
  input  logic                      masking_req_i,
  output logic                      clearing_ack_o,
  output logic                      masking_ack_o,
  output logic                      edn_req_o,
  input  logic                      edn_ack_i,
  input  aes_wrap_pkg::entropy_t    edn_data_i,
  output aes_wrap_pkg::entropy_t    entropy_o,
  // Key vault
  output aes_wrap_pkg::kv_data_t    kv_data_o,
  output logic                      kv_valid_o,
  input  logic                      clear_secrets_i,
  input  logic                      kv_write_done_i
);

  logic                    kv_en;
  logic                    block_output;
  aes_wrap_pkg::key_size_t key_size;
  logic                    data_out_clear;
  logic                    sw_dout_last_rd;
  logic                    dout_visible;
  logic                    output_valid;

  //////////////////////////////////////////////////////////////////////
  // Register block
  //////////////////////////////////////////////////////////////////////

  aes_wrap_wb_regs u_regs (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .wb_cyc_i          (wb_cyc_i),
    .wb_stb_i          (wb_stb_i),
    .wb_we_i           (wb_we_i),
    .wb_adr_i          (wb_adr_i),
    .wb_dat_i          (wb_dat_i),
    .wb_dat_o          (wb_dat_o),
    .wb_ack_o          (wb_ack_o),
    .core_din_o        (core_din_o),
    .core_din_idx_o    (core_din_idx_o),
    .core_din_we_o     (core_din_we_o),
    .core_block_i      (core_block_i),
    .core_out_valid_i  (core_out_valid_i),
    .dout_visible_i    (dout_visible),
    .output_valid_i    (output_valid),
    .kv_valid_i        (kv_valid_o),
    .kv_en_o           (kv_en),
    .block_output_o    (block_output),
    .key_size_o        (key_size),
    .data_out_clear_o  (data_out_clear),
    .sw_dout_last_rd_o (sw_dout_last_rd)
  );

  //////////////////////////////////////////////////////////////////////
  // Key-vault intercept
  //////////////////////////////////////////////////////////////////////

  aes_wrap_kv_capture u_kv (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .kv_en_i           (kv_en),
    .block_output_i    (block_output),
    .key_size_i        (key_size),
    .din_we_i          (core_din_we_o),
    .din_idx_i         (core_din_idx_o),
    .sw_dout_last_rd_i (sw_dout_last_rd),
    .data_out_clear_i  (data_out_clear),
    .core_out_valid_i  (core_out_valid_i),
    .core_block_i      (core_block_i),
    .core_idle_i       (core_idle_i),
    .core_dout_ack_o   (core_dout_ack_o),
    .clear_secrets_i   (clear_secrets_i),
    .kv_write_done_i   (kv_write_done_i),
    .kv_data_o         (kv_data_o),
    .kv_valid_o        (kv_valid_o),
    .output_valid_o    (output_valid),
    .dout_visible_o    (dout_visible)
  );

  //////////////////////////////////////////////////////////////////////
  // Entropy
  //////////////////////////////////////////////////////////////////////

  aes_wrap_edn_arb u_edn (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clearing_req_i (clearing_req_i),
    .masking_req_i  (masking_req_i),
    .clearing_ack_o (clearing_ack_o),
    .masking_ack_o  (masking_ack_o),
    .edn_req_o      (edn_req_o),
    .edn_ack_i      (edn_ack_i),
    .edn_data_i     (edn_data_i),
    .entropy_o      (entropy_o)
  );

endmodule

`default_nettype wire

// ==== rtl/aes_wrap_wb_regs.sv ====
/*
 * AES wrapper register block
 * Wishbone classic slave with control, trigger, status, data-in
 * and concealed data-out registers
 */
`timescale 1ns/1ps
`default_nettype none

`include "aes_wrap_settings.svh"

module aes_wrap_wb_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Wishbone
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  aes_wrap_pkg::wb_addr_t    wb_adr_i,
  input  aes_wrap_pkg::wb_data_t    wb_dat_i,
  output aes_wrap_pkg::wb_data_t    wb_dat_o,
  output logic                      wb_ack_o,
  // Core side
  output aes_wrap_pkg::wb_data_t    core_din_o,
  output aes_wrap_pkg::word_idx_t   core_din_idx_o,
  output logic                      core_din_we_o,
  input  aes_wrap_pkg::data_block_t core_block_i,
  input  logic                      core_out_valid_i,
  // Key-vault intercept
  input  logic                      dout_visible_i,
  input  logic                      output_valid_i,
  input  logic                      kv_valid_i,
  output logic                      kv_en_o,
  output logic                      block_output_o,
  output aes_wrap_pkg::key_size_t   key_size_o,
  output logic                      data_out_clear_o,
  output logic                      sw_dout_last_rd_o
);

  logic                    req;
  logic                    wr_req;
  logic                    rd_req;
  logic                    is_din;
  logic                    is_dout;
  logic                    clear_trig;
  logic                    output_lost_q;
  aes_wrap_pkg::word_idx_t din_idx;
  aes_wrap_pkg::word_idx_t dout_idx;
  aes_wrap_pkg::wb_data_t  rdata;

  //////////////////////////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////////////////////////

  // New cycle only while ack is low, so each access is taken once
  assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_req = req & wb_we_i;
  assign rd_req = req & ~wb_we_i;

  assign is_din  = (wb_adr_i >= aes_wrap_pkg::wb_addr_t'(`AES_WRAP_ADDR_DATA_IN0)) &&
                   (wb_adr_i <= aes_wrap_pkg::wb_addr_t'(`AES_WRAP_ADDR_DATA_IN0 + 3));
  assign is_dout = (wb_adr_i >= aes_wrap_pkg::wb_addr_t'(`AES_WRAP_ADDR_DATA_OUT0)) &&
                   (wb_adr_i <= aes_wrap_pkg::wb_addr_t'(`AES_WRAP_ADDR_DATA_OUT0 + 3));

  assign din_idx  = aes_wrap_pkg::word_idx_t'(
                      wb_adr_i - aes_wrap_pkg::wb_addr_t'(`AES_WRAP_ADDR_DATA_IN0));
  assign dout_idx = aes_wrap_pkg::word_idx_t'(
                      wb_adr_i - aes_wrap_pkg::wb_addr_t'(`AES_WRAP_ADDR_DATA_OUT0));

  assign clear_trig = wr_req && wb_dat_i[0] &&
                      (wb_adr_i == aes_wrap_pkg::wb_addr_t'(`AES_WRAP_ADDR_TRIGGER));

  // Ack and the side-band pulses all line up on the same edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o          <= 1'b0;
      core_din_we_o     <= 1'b0;
      data_out_clear_o  <= 1'b0;
      sw_dout_last_rd_o <= 1'b0;
    end else begin
      wb_ack_o          <= req;
      core_din_we_o     <= wr_req & is_din;
      data_out_clear_o  <= clear_trig;
      sw_dout_last_rd_o <= rd_req &&
                           (wb_adr_i == aes_wrap_pkg::wb_addr_t'(`AES_WRAP_ADDR_DATA_OUT0 + 3));
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      wb_dat_o <= rdata;
    end
    if (wr_req && is_din) begin
      core_din_o     <= wb_dat_i;
      core_din_idx_o <= din_idx;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control and status
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      kv_en_o        <= 1'b0;
      block_output_o <= 1'b0;
      key_size_o     <= '0;
    end else if (wr_req && (wb_adr_i == aes_wrap_pkg::wb_addr_t'(`AES_WRAP_ADDR_CTRL))) begin
      kv_en_o        <= wb_dat_i[`AES_WRAP_CTRL_KV_EN];
      block_output_o <= wb_dat_i[`AES_WRAP_CTRL_BLOCK];
      key_size_o     <= wb_dat_i[`AES_WRAP_CTRL_KSIZE_LSB +: `AES_WRAP_KSIZE_W];
    end
  end

  // Sticky until the clear trigger; a block arriving while blocked is lost
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      output_lost_q <= 1'b0;
    end else if (clear_trig) begin
      output_lost_q <= 1'b0;
    end else if (core_out_valid_i && block_output_o) begin
      output_lost_q <= 1'b1;
    end
  end

  // Read mux, data-out words read as zero unless visible
  always_comb begin
    rdata = '0;
    if (wb_adr_i == aes_wrap_pkg::wb_addr_t'(`AES_WRAP_ADDR_CTRL)) begin
      rdata[`AES_WRAP_CTRL_KV_EN]                             = kv_en_o;
      rdata[`AES_WRAP_CTRL_BLOCK]                             = block_output_o;
      rdata[`AES_WRAP_CTRL_KSIZE_LSB +: `AES_WRAP_KSIZE_W]    = key_size_o;
    end else if (wb_adr_i == aes_wrap_pkg::wb_addr_t'(`AES_WRAP_ADDR_STATUS)) begin
      rdata[`AES_WRAP_STATUS_OUTPUT_VALID] = output_valid_i;
      rdata[`AES_WRAP_STATUS_OUTPUT_LOST]  = output_lost_q;
      rdata[`AES_WRAP_STATUS_KV_VALID]     = kv_valid_i;
    end else if (is_dout && dout_visible_i) begin
      rdata = core_block_i[dout_idx*`AES_WRAP_WORD_W +: `AES_WRAP_WORD_W];
    end
  end

endmodule

`default_nettype wire

// ==== sim/aes_wrap_properties.sv ====
/*
 * AES wrapper handshake assertions
 * Bus ack pulse width, entropy request hold and acknowledge exclusivity
 */
`timescale 1ns/1ps
`default_nettype none

module aes_wrap_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic wb_ack_i,
  input logic edn_req_i,
  input logic edn_ack_i,
  input logic clearing_ack_i,
  input logic masking_ack_i
);

  // Failed assertion count
  int fail_cnt = 0;

  // One ack per access
  ack_pulse_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_i |=> !wb_ack_i)
    else begin
      $error("wb_ack_o stayed high for two cycles");
      fail_cnt++;
    end

  // Entropy request is held towards the source until acknowledged
  req_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_req_i && !edn_ack_i |=> edn_req_i)
    else begin
      $error("edn_req_o dropped before edn_ack_i");
      fail_cnt++;
    end

  ack_excl_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(clearing_ack_i && masking_ack_i))
    else begin
      $error("clearing_ack_o and masking_ack_o high together");
      fail_cnt++;
    end

endmodule

bind aes_wrap_top aes_wrap_properties u_props (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .wb_ack_i       (wb_ack_o),
  .edn_req_i      (edn_req_o),
  .edn_ack_i      (edn_ack_i),
  .clearing_ack_i (clearing_ack_o),
  .masking_ack_i  (masking_ack_o)
);

`default_nettype wire

// ==== sim/aes_wrap_tb.sv ====
/*
 * AES wrapper testbench
 * Plays the cipher core and entropy source, checks capture, concealment,
 * output lost, clearing and entropy arbitration against a model
 */
`timescale 1ns/1ps
`default_nettype none

`include "aes_wrap_settings.svh"

module aes_wrap_tb;

  localparam int num_ops        = 40;
  localparam int op_cycles      = 60;
  localparam int timeout_cycles = num_ops * op_cycles + 500;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      wb_cyc_i;
  logic                      wb_stb_i;
  logic                      wb_we_i;
  aes_wrap_pkg::wb_addr_t    wb_adr_i;
  aes_wrap_pkg::wb_data_t    wb_dat_i;
  aes_wrap_pkg::wb_data_t    wb_dat_o;
  logic                      wb_ack_o;
  aes_wrap_pkg::wb_data_t    core_din_o;
  aes_wrap_pkg::word_idx_t   core_din_idx_o;
  logic                      core_din_we_o;
  aes_wrap_pkg::data_block_t core_block_i;
  logic                      core_out_valid_i;
  logic                      core_dout_ack_o;
  logic                      core_idle_i;
  logic                      clearing_req_i;
  logic                      masking_req_i;
  logic                      clearing_ack_o;
  logic                      masking_ack_o;
  logic                      edn_req_o;
  logic                      edn_ack_i;
  aes_wrap_pkg::entropy_t    edn_data_i;
  aes_wrap_pkg::entropy_t    entropy_o;
  aes_wrap_pkg::kv_data_t    kv_data_o;
  logic                      kv_valid_o;
  logic                      clear_secrets_i;
  logic                      kv_write_done_i;

  // Reference model state
  aes_wrap_pkg::kv_data_t    exp_kv;
  logic                      exp_kv_valid;
  logic                      exp_lost;

  int          n_checks  = 0;
  int          n_errors  = 0;
  int          dout_acks = 0;
  int          din_wes   = 0;
  int          cycle_cnt;

  aes_wrap_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Core sees one pulse per block consumed and per data-in word
  always @(negedge clk_i) begin
    if (rst_ni === 1'b1 && core_dout_ack_o === 1'b1) begin
      dout_acks++;
    end
    if (rst_ni === 1'b1 && core_din_we_o === 1'b1) begin
      din_wes++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input aes_wrap_pkg::wb_data_t got,
                            input aes_wrap_pkg::wb_data_t exp_val);
    n_checks++;
    if (got !== exp_val) begin
      n_errors++;
      $display("error @%0t: %s = %h, expected %h", $time, name, got, exp_val);
    end
  endtask

  task automatic check_kv(input string name, input aes_wrap_pkg::kv_data_t got,
                          input aes_wrap_pkg::kv_data_t exp_val);
    n_checks++;
    if (got !== exp_val) begin
      n_errors++;
      $display("error @%0t: %s = %h, expected %h", $time, name, got, exp_val);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp_val);
    n_checks++;
    if (got !== exp_val) begin
      n_errors++;
      $display("error @%0t: %s = %b, expected %b", $time, name, got, exp_val);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus and core helpers
  //////////////////////////////////////////////////////////////////////

  task automatic bus_cycle(input logic we, input int adr, input aes_wrap_pkg::wb_data_t wdat,
                           output aes_wrap_pkg::wb_data_t rdat);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= aes_wrap_pkg::wb_addr_t'(adr);
    wb_dat_i <= wdat;
    @(negedge clk_i);
    while (!wb_ack_o) begin
      @(negedge clk_i);
    end
    rdat = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic bus_write(input int adr, input aes_wrap_pkg::wb_data_t dat);
    aes_wrap_pkg::wb_data_t unused_rd;
    bus_cycle(1'b1, adr, dat, unused_rd);
  endtask

  task automatic bus_read(input int adr, output aes_wrap_pkg::wb_data_t rd);
    bus_cycle(1'b0, adr, '0, rd);
  endtask

  function automatic aes_wrap_pkg::data_block_t random_block();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // Word 0 goes first and arms the intercept
  task automatic write_din();
    int w;
    int wes_start;
    aes_wrap_pkg::wb_data_t dat;
    wes_start = din_wes;
    for (w = 0; w < 4; w++) begin
      dat = $urandom();
      bus_write(`AES_WRAP_ADDR_DATA_IN0 + w, dat);
      check_word("core_din_o", core_din_o, dat);
      check_word("core_din_idx_o", aes_wrap_pkg::wb_data_t'(core_din_idx_o),
                 aes_wrap_pkg::wb_data_t'(w));
    end
    check_word("core_din_we_o count", aes_wrap_pkg::wb_data_t'(din_wes - wes_start), 4);
  endtask

  task automatic send_block(input aes_wrap_pkg::data_block_t blk, input logic wait_ack);
    int n;
    @(posedge clk_i);
    core_block_i     <= blk;
    core_out_valid_i <= 1'b1;
    @(posedge clk_i);
    core_out_valid_i <= 1'b0;
    if (wait_ack) begin
      n = 0;
      @(negedge clk_i);
      while (!core_dout_ack_o && n < 8) begin
        @(negedge clk_i);
        n++;
      end
      if (!core_dout_ack_o) begin
        n_errors++;
        $display("error @%0t: core_dout_ack_o never followed the output block", $time);
      end
    end
    repeat (3) @(posedge clk_i);
  endtask

  task automatic read_dout(input logic visible, input aes_wrap_pkg::data_block_t blk);
    int j;
    aes_wrap_pkg::wb_data_t rd;
    for (j = 0; j < 4; j++) begin
      bus_read(`AES_WRAP_ADDR_DATA_OUT0 + j, rd);
      check_word("wb_dat_o (DATA_OUT)", rd, visible ? blk[j*32 +: 32] : '0);
    end
  endtask

  task automatic read_status(input logic exp_ov);
    aes_wrap_pkg::wb_data_t rd;
    aes_wrap_pkg::wb_data_t exp_val;
    exp_val = '0;
    exp_val[`AES_WRAP_STATUS_OUTPUT_VALID] = exp_ov;
    exp_val[`AES_WRAP_STATUS_OUTPUT_LOST]  = exp_lost;
    exp_val[`AES_WRAP_STATUS_KV_VALID]     = exp_kv_valid;
    bus_read(`AES_WRAP_ADDR_STATUS, rd);
    check_word("wb_dat_o (STATUS)", rd, exp_val);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Operations
  //////////////////////////////////////////////////////////////////////

  task automatic capture_op();
    int nblk;
    int b;
    int acks_start;
    aes_wrap_pkg::data_block_t blk;
    aes_wrap_pkg::wb_data_t    ctrl;
    nblk = $urandom_range(1, 4);
    ctrl = '0;
    ctrl[`AES_WRAP_CTRL_KV_EN] = 1'b1;
    ctrl[`AES_WRAP_CTRL_KSIZE_LSB +: `AES_WRAP_KSIZE_W] = aes_wrap_pkg::key_size_t'(nblk * 16);
    @(posedge clk_i);
    core_idle_i <= 1'b0;
    bus_write(`AES_WRAP_ADDR_CTRL, ctrl);
    write_din();
    acks_start = dout_acks;
    for (b = 0; b < nblk; b++) begin
      blk = random_block();
      send_block(blk, 1'b1);
      exp_kv[b*`AES_WRAP_BLOCK_W +: `AES_WRAP_BLOCK_W] = blk;
    end
    check_word("core_dout_ack_o count", aes_wrap_pkg::wb_data_t'(dout_acks - acks_start),
               aes_wrap_pkg::wb_data_t'(nblk));
    read_dout(1'b0, blk);
    // Idle rise at the last chunk ends the operation
    @(posedge clk_i);
    core_idle_i <= 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    exp_kv_valid = 1'b1;
    check_bit("kv_valid_o", kv_valid_o, exp_kv_valid);
    check_kv("kv_data_o", kv_data_o, exp_kv);
    read_status(1'b0);
  endtask

  task automatic plain_op();
    int acks_start;
    aes_wrap_pkg::data_block_t blk;
    bus_write(`AES_WRAP_ADDR_CTRL, '0);
    write_din();
    blk        = random_block();
    acks_start = dout_acks;
    send_block(blk, 1'b0);
    read_status(1'b1);
    read_dout(1'b1, blk);
    check_word("core_dout_ack_o count", aes_wrap_pkg::wb_data_t'(dout_acks - acks_start), 1);
  endtask

  task automatic blocked_op();
    aes_wrap_pkg::data_block_t blk;
    aes_wrap_pkg::wb_data_t    ctrl;
    ctrl = '0;
    ctrl[`AES_WRAP_CTRL_BLOCK] = 1'b1;
    bus_write(`AES_WRAP_ADDR_CTRL, ctrl);
    write_din();
    blk = random_block();
    send_block(blk, 1'b0);
    exp_lost = 1'b1;
    read_status(1'b1);
    read_dout(1'b0, blk);
  endtask

  // 0 write done, 1 clear secrets, else trigger write
  task automatic clear_op(input int kind);
    case (kind)
      0: begin
        @(posedge clk_i);
        kv_write_done_i <= 1'b1;
        @(posedge clk_i);
        kv_write_done_i <= 1'b0;
      end
      1: begin
        @(posedge clk_i);
        clear_secrets_i <= 1'b1;
        @(posedge clk_i);
        clear_secrets_i <= 1'b0;
      end
      default: begin
        bus_write(`AES_WRAP_ADDR_TRIGGER, 32'h1);
        exp_lost = 1'b0;
      end
    endcase
    @(negedge clk_i);
    exp_kv       = '0;
    exp_kv_valid = 1'b0;
    check_kv("kv_data_o", kv_data_o, exp_kv);
    check_bit("kv_valid_o", kv_valid_o, exp_kv_valid);
  endtask

  task automatic entropy_round();
    logic clr;
    logic msk;
    logic drop;
    int   delay;
    int   k;
    aes_wrap_pkg::entropy_t data;
    clr   = $urandom_range(0, 1);
    msk   = $urandom_range(0, 1);
    msk   = msk | ~clr;
    drop  = ($urandom_range(0, 3) == 0);
    delay = $urandom_range(1, 4);
    data  = $urandom();
    @(posedge clk_i);
    clearing_req_i <= clr;
    masking_req_i  <= msk;
    edn_data_i     <= data;
    for (k = 0; k < delay; k++) begin
      @(negedge clk_i);
      check_bit("edn_req_o", edn_req_o, 1'b1);
      check_bit("clearing_ack_o", clearing_ack_o, 1'b0);
      check_bit("masking_ack_o", masking_ack_o, 1'b0);
      @(posedge clk_i);
      // Requester gives up early, the held request must stay up
      if (drop) begin
        clearing_req_i <= 1'b0;
        masking_req_i  <= 1'b0;
        clr = 1'b0;
        msk = 1'b0;
      end
    end
    edn_ack_i <= 1'b1;
    @(negedge clk_i);
    check_bit("edn_req_o", edn_req_o, 1'b1);
    check_bit("clearing_ack_o", clearing_ack_o, clr);
    check_bit("masking_ack_o", masking_ack_o, ~clr & msk);
    check_word("entropy_o", entropy_o, data);
    @(posedge clk_i);
    edn_ack_i      <= 1'b0;
    clearing_req_i <= 1'b0;
    masking_req_i  <= 1'b0;
    @(negedge clk_i);
    check_bit("edn_req_o", edn_req_o, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and timeout
  //////////////////////////////////////////////////////////////////////

  initial begin
    int op;
    void'($urandom(32'h292d));
    rst_ni           = 1'b0;
    wb_cyc_i         = 1'b0;
    wb_stb_i         = 1'b0;
    wb_we_i          = 1'b0;
    wb_adr_i         = '0;
    wb_dat_i         = '0;
    core_block_i     = '0;
    core_out_valid_i = 1'b0;
    core_idle_i      = 1'b1;
    clearing_req_i   = 1'b0;
    masking_req_i    = 1'b0;
    edn_ack_i        = 1'b0;
    edn_data_i       = '0;
    clear_secrets_i  = 1'b0;
    kv_write_done_i  = 1'b0;
    exp_kv           = '0;
    exp_kv_valid     = 1'b0;
    exp_lost         = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (op = 0; op < 12; op++) begin
      capture_op();
      clear_op(op % 3);
    end
    for (op = 0; op < 4; op++) begin
      plain_op();
      blocked_op();
    end
    // Output lost survives a capture and goes with the trigger
    capture_op();
    clear_op(2);
    read_status(1'b0);
    for (op = 0; op < 16; op++) begin
      entropy_round();
    end

    repeat (2) @(posedge clk_i);
    n_errors += DUT.u_props.fail_cnt;
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
